/* Makefile */
TOP = qdr_cpu_bridge_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert --timescale 1ns/1ps \
	  -f files.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP)

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f files.f --top-module $(TOP)
	verilator --lint-only --timescale 1ns/1ps +incdir+include \
	  design/qdr_bus_pkg.sv design/qdr_mem_pkg.sv design/qdr_reg_bank.sv \
	  design/qdr_cdc_handshake.sv design/qdr_burst_ctrl.sv design/qdr_cpu_bridge.sv \
	  --top-module qdr_cpu_bridge

clean:
	rm -rf obj_dir

/* design/qdr_burst_ctrl.sv */
`timescale 1ns/1ps

module qdr_burst_ctrl
  import qdr_mem_pkg::*;
(
  input  logic        qdr_clk,
  input  logic        qdr_rst,
  input  logic        rd_req,
  input  logic        wr_req,
  output logic        rd_ack,
  output logic        wr_ack,
  input  burst_t      wr_burst,
  output burst_t      rd_burst,
  output logic        wr_en,
  output logic        rd_en,
  output logic [71:0] wr_data,
  input  qdr_rsp_t    qdr_rsp
);

  wr_state_t wr_state;
  rd_state_t rd_state;

  // the write is acknowledged first and only runs once the request
  // has dropped, so the bus side is already free when the burst goes out.
  always_ff @(posedge qdr_clk) begin
    if (qdr_rst) begin
      wr_state <= WR_IDLE;
      wr_ack   <= 1'b0;
      wr_en    <= 1'b0;
    end else begin
      wr_en <= 1'b0;
      case (wr_state)
        WR_IDLE: begin
          if (wr_req) begin
            wr_ack   <= 1'b1;
            wr_state <= WR_ACK;
          end
        end
        WR_ACK: begin
          if (!wr_req) begin
            wr_ack   <= 1'b0;
            wr_en    <= 1'b1;
            wr_state <= WR_HI;
          end
        end
        WR_HI: begin
          wr_state <= WR_LO;
        end
        WR_LO: begin
          wr_state <= WR_IDLE;
        end
        default: begin
          wr_state <= WR_IDLE;
        end
      endcase
    end
  end

  // hi beat rides with the enable, lo beat follows on the next cycle.
  assign wr_data = wr_en ? wr_burst.hi : wr_burst.lo;

  always_ff @(posedge qdr_clk) begin
    if (qdr_rst) begin
      rd_state <= RD_IDLE;
      rd_ack   <= 1'b0;
      rd_en    <= 1'b0;
    end else begin
      rd_en <= 1'b0;
      case (rd_state)
        RD_IDLE: begin
          if (rd_req) begin
            rd_en    <= 1'b1;
            rd_state <= RD_HI;
          end
        end
        RD_HI: begin
          if (qdr_rsp.rd_dvld) begin
            rd_state <= RD_LO;
          end
        end
        RD_LO: begin
          if (qdr_rsp.rd_dvld) begin
            rd_ack   <= 1'b1;
            rd_state <= RD_ACK;
          end
        end
        RD_ACK: begin
          if (!rd_req) begin
            rd_ack   <= 1'b0;
            rd_state <= RD_IDLE;
          end
        end
        default: begin
          rd_state <= RD_IDLE;
        end
      endcase
    end
  end

  // the read buffer is only sampled by the bus once rd_ack has been seen.
  always_ff @(posedge qdr_clk) begin
    if (rd_state == RD_HI && qdr_rsp.rd_dvld) begin
      rd_burst.hi <= qdr_rsp.rd_data;
    end
    if (rd_state == RD_LO && qdr_rsp.rd_dvld) begin
      rd_burst.lo <= qdr_rsp.rd_data;
    end
  end

endmodule

/* design/qdr_bus_pkg.sv */
package qdr_bus_pkg;

  // one host bus access as seen by the bridge.
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        rnw;
    logic        select;
  } bus_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        xfer_ack;
  } bus_rsp_t;

  // word index taken from address bits 6 to 2.
  typedef enum logic [4:0] {
    REG_STATUS = 5'd0,
    REG_CTRL   = 5'd1,
    REG_ADDR   = 5'd2,
    REG_WR0    = 5'd8,
    REG_WR1    = 5'd9,
    REG_WR2    = 5'd10,
    REG_WR3    = 5'd11,
    REG_WR4    = 5'd12,
    REG_RD0    = 5'd16,
    REG_RD1    = 5'd17,
    REG_RD2    = 5'd18,
    REG_RD3    = 5'd19,
    REG_RD4    = 5'd20
  } reg_word_t;

endpackage

/* design/qdr_cdc_handshake.sv */
`timescale 1ns/1ps
`include "qdr_config.svh"

module qdr_cdc_handshake
  import qdr_mem_pkg::*;
(
  input  logic        bus_clk,
  input  logic        bus_rst,
  input  logic        qdr_clk,
  input  logic        qdr_rst,
  input  logic        rd_pend,
  input  logic        wr_pend,
  output logic        rd_req,
  output logic        wr_req,
  input  logic        rd_ack,
  input  logic        wr_ack,
  output logic        rd_done,
  output logic        wr_done,
  input  phy_status_t phy_async,
  output phy_status_t phy_sync
);

  // each chain element holds one sample of every level in the bundle.
  logic [`QDR_SYNC_STAGES-1:0][1:0] req_chain;
  logic [`QDR_SYNC_STAGES-1:0][3:0] ack_chain;

  // pending levels into the memory domain.
  always_ff @(posedge qdr_clk) begin
    if (qdr_rst) begin
      req_chain <= '0;
    end else begin
      req_chain <= {req_chain[`QDR_SYNC_STAGES-2:0], rd_pend, wr_pend};
    end
  end

  assign {rd_req, wr_req} = req_chain[`QDR_SYNC_STAGES-1];

  // acknowledges and PHY status back into the bus domain.
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      ack_chain <= '0;
    end else begin
      ack_chain <= {ack_chain[`QDR_SYNC_STAGES-2:0],
                    rd_ack, wr_ack, phy_async.phy_rdy, phy_async.cal_fail};
    end
  end

  assign {rd_done, wr_done, phy_sync.phy_rdy, phy_sync.cal_fail} =
    ack_chain[`QDR_SYNC_STAGES-1];

endmodule

/* design/qdr_cpu_bridge.sv */
`timescale 1ns/1ps

module qdr_cpu_bridge
  import qdr_bus_pkg::*;
  import qdr_mem_pkg::*;
(
  input  logic        bus_clk,
  input  logic        bus_rst,
  input  logic        qdr_clk,
  input  logic        qdr_rst,
  input  bus_req_t    bus_req,
  output bus_rsp_t    bus_rsp,
  input  phy_status_t phy_status,
  output qdr_cmd_t    qdr_cmd,
  input  qdr_rsp_t    qdr_rsp
);

  logic        rd_pend;
  logic        wr_pend;
  logic        rd_req;
  logic        wr_req;
  logic        rd_ack;
  logic        wr_ack;
  logic        rd_done;
  logic        wr_done;
  phy_status_t phy_sync;
  logic [31:0] qdr_addr;
  burst_t      wr_burst;
  burst_t      rd_burst;
  logic        wr_en;
  logic        rd_en;
  logic [71:0] wr_data;

  qdr_reg_bank reg_bank0 (
    .bus_clk  (bus_clk),
    .bus_rst  (bus_rst),
    .bus_req  (bus_req),
    .bus_rsp  (bus_rsp),
    .status   (phy_sync),
    .rd_done  (rd_done),
    .wr_done  (wr_done),
    .rd_pend  (rd_pend),
    .wr_pend  (wr_pend),
    .qdr_addr (qdr_addr),
    .wr_burst (wr_burst),
    .rd_burst (rd_burst)
  );

  qdr_cdc_handshake cdc0 (
    .bus_clk   (bus_clk),
    .bus_rst   (bus_rst),
    .qdr_clk   (qdr_clk),
    .qdr_rst   (qdr_rst),
    .rd_pend   (rd_pend),
    .wr_pend   (wr_pend),
    .rd_req    (rd_req),
    .wr_req    (wr_req),
    .rd_ack    (rd_ack),
    .wr_ack    (wr_ack),
    .rd_done   (rd_done),
    .wr_done   (wr_done),
    .phy_async (phy_status),
    .phy_sync  (phy_sync)
  );

  qdr_burst_ctrl burst_ctrl0 (
    .qdr_clk  (qdr_clk),
    .qdr_rst  (qdr_rst),
    .rd_req   (rd_req),
    .wr_req   (wr_req),
    .rd_ack   (rd_ack),
    .wr_ack   (wr_ack),
    .wr_burst (wr_burst),
    .rd_burst (rd_burst),
    .wr_en    (wr_en),
    .rd_en    (rd_en),
    .wr_data  (wr_data),
    .qdr_rsp  (qdr_rsp)
  );

  // the SRAM address is the quasi-static register value.
  assign qdr_cmd = '{address: qdr_addr, wr_en: wr_en, wr_data: wr_data, rd_en: rd_en};

endmodule

/* design/qdr_mem_pkg.sv */
package qdr_mem_pkg;

  // a full 144-bit transfer, the hi beat goes out first.
  typedef struct packed {
    logic [71:0] hi;
    logic [71:0] lo;
  } burst_t;

  typedef struct packed {
    logic [31:0] address;
    logic        wr_en;
    logic [71:0] wr_data;
    logic        rd_en;
  } qdr_cmd_t;

  typedef struct packed {
    logic [71:0] rd_data;
    logic        rd_dvld;
  } qdr_rsp_t;

  typedef struct packed {
    logic phy_rdy;
    logic cal_fail;
  } phy_status_t;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_ACK,
    WR_HI,
    WR_LO
  } wr_state_t;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_HI,
    RD_LO,
    RD_ACK
  } rd_state_t;

endpackage

/* design/qdr_reg_bank.sv */
`timescale 1ns/1ps
`include "qdr_config.svh"

module qdr_reg_bank
  import qdr_bus_pkg::*;
  import qdr_mem_pkg::*;
(
  input  logic        bus_clk,
  input  logic        bus_rst,
  input  bus_req_t    bus_req,
  output bus_rsp_t    bus_rsp,
  input  phy_status_t status,
  input  logic        rd_done,
  input  logic        wr_done,
  output logic        rd_pend,
  output logic        wr_pend,
  output logic [31:0] qdr_addr,
  output burst_t      wr_burst,
  input  burst_t      rd_burst
);

  logic [31:0]  local_addr;
  logic         addr_match;
  logic         take;
  logic         xfer_ack;
  reg_word_t    word;
  logic [31:0]  addr_reg;
  logic [143:0] wr_buf;
  logic [143:0] rd_bits;
  logic         rd_busy;
  logic         wr_busy;
  logic [31:0]  rdata;

  assign local_addr = bus_req.addr - `QDR_BASE_ADDR;
  assign addr_match = (bus_req.addr >= `QDR_BASE_ADDR) && (bus_req.addr < `QDR_HIGH_ADDR);
  assign take       = bus_req.select && addr_match && !xfer_ack;
  assign word       = reg_word_t'(local_addr[6:2]);

  // a transfer counts as busy until its acknowledge has returned low,
  // so a new go bit never meets a stale done level.
  assign rd_busy = rd_pend | rd_done;
  assign wr_busy = wr_pend | wr_done;

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      xfer_ack <= 1'b0;
    end else begin
      xfer_ack <= take;
    end
  end

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
    end else begin
      if (rd_done) begin
        rd_pend <= 1'b0;
      end
      if (wr_done) begin
        wr_pend <= 1'b0;
      end
      if (take && !bus_req.rnw && word == REG_CTRL) begin
        if (bus_req.wdata[0]) begin
          if (!rd_busy) begin
            rd_pend <= 1'b1;
          end
        end else if (bus_req.wdata[8] && !wr_busy) begin
          wr_pend <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge bus_clk) begin
    if (take && !bus_req.rnw) begin
      case (word)
        REG_ADDR: addr_reg          <= bus_req.wdata;
        REG_WR0:  wr_buf[143:128]   <= bus_req.wdata[15:0];
        REG_WR1:  wr_buf[127:96]    <= bus_req.wdata;
        REG_WR2:  wr_buf[95:64]     <= bus_req.wdata;
        REG_WR3:  wr_buf[63:32]     <= bus_req.wdata;
        REG_WR4:  wr_buf[31:0]      <= bus_req.wdata;
        default: ;
      endcase
    end
  end

  assign rd_bits = rd_burst;

  // the host holds its address through the acknowledge cycle.
  always_comb begin
    rdata = '0;
    if (xfer_ack) begin
      case (word)
        REG_STATUS: rdata = {23'b0, status.cal_fail, 7'b0, status.phy_rdy};
        REG_CTRL:   rdata = {23'b0, wr_busy, 7'b0, rd_busy};
        REG_ADDR:   rdata = addr_reg;
        REG_WR0:    rdata = {16'b0, wr_buf[143:128]};
        REG_WR1:    rdata = wr_buf[127:96];
        REG_WR2:    rdata = wr_buf[95:64];
        REG_WR3:    rdata = wr_buf[63:32];
        REG_WR4:    rdata = wr_buf[31:0];
        REG_RD0:    rdata = {16'b0, rd_bits[143:128]};
        REG_RD1:    rdata = rd_bits[127:96];
        REG_RD2:    rdata = rd_bits[95:64];
        REG_RD3:    rdata = rd_bits[63:32];
        REG_RD4:    rdata = rd_bits[31:0];
        default:    rdata = '0;
      endcase
    end
  end

  assign bus_rsp  = '{rdata: rdata, xfer_ack: xfer_ack};
  assign qdr_addr = addr_reg;
  assign wr_burst = wr_buf;

endmodule

/* files.f */
+incdir+include
design/qdr_bus_pkg.sv
design/qdr_mem_pkg.sv
design/qdr_reg_bank.sv
design/qdr_cdc_handshake.sv
design/qdr_burst_ctrl.sv
design/qdr_cpu_bridge.sv
test/qdr_mem_model.sv
test/qdr_cpu_bridge_chk.sv
test/qdr_cpu_bridge_tb.sv

/* include/qdr_config.svh */
`ifndef QDR_CONFIG_SVH
`define QDR_CONFIG_SVH

// byte-address window of the bridge on the host bus.
// The base is included and the high address is excluded.
`define QDR_BASE_ADDR 32'h0001_0000
`define QDR_HIGH_ADDR 32'h0001_0080

// depth of every synchronizer chain between bus_clk and qdr_clk.
`define QDR_SYNC_STAGES 2

// number of 144-bit bursts held by the behavioral memory.
`define QDR_MEM_WORDS 64

`endif

/* test/qdr_cpu_bridge_chk.sv */
`timescale 1ns/1ps

module qdr_cpu_bridge_chk
  import qdr_bus_pkg::*;
  import qdr_mem_pkg::*;
(
  input logic     bus_clk,
  input logic     bus_rst,
  input logic     qdr_clk,
  input logic     qdr_rst,
  input bus_rsp_t bus_rsp,
  input qdr_cmd_t qdr_cmd,
  input logic     rd_ack
);

  logic rd_open;
  logic rd_ack_q;
  logic ack_fail = 1'b0;
  logic rdata_fail = 1'b0;
  logic wr_en_fail = 1'b0;
  logic rd_en_fail = 1'b0;
  logic any_fail;

  assign any_fail = ack_fail | rdata_fail | wr_en_fail | rd_en_fail;

  // a read stays open from its rd_en until rd_ack has risen and fallen again.
  always_ff @(posedge qdr_clk) begin
    if (qdr_rst) begin
      rd_open  <= 1'b0;
      rd_ack_q <= 1'b0;
    end else begin
      rd_ack_q <= rd_ack;
      if (qdr_cmd.rd_en) begin
        rd_open <= 1'b1;
      end else if (rd_ack_q && !rd_ack) begin
        rd_open <= 1'b0;
      end
    end
  end

  ack_one_cycle: assert property (@(posedge bus_clk) disable iff (bus_rst)
    bus_rsp.xfer_ack |=> !bus_rsp.xfer_ack)
    else begin
      ack_fail = 1'b1;
      $error("xfer_ack high for two cycles in a row");
    end

  rdata_idle_zero: assert property (@(posedge bus_clk) disable iff (bus_rst)
    !bus_rsp.xfer_ack |-> bus_rsp.rdata == 32'd0)
    else begin
      rdata_fail = 1'b1;
      $error("rdata not zero while xfer_ack is low");
    end

  wr_en_pulse: assert property (@(posedge qdr_clk) disable iff (qdr_rst)
    qdr_cmd.wr_en |=> !qdr_cmd.wr_en)
    else begin
      wr_en_fail = 1'b1;
      $error("wr_en longer than one cycle");
    end

  rd_en_single: assert property (@(posedge qdr_clk) disable iff (qdr_rst)
    qdr_cmd.rd_en |-> !rd_open)
    else begin
      rd_en_fail = 1'b1;
      $error("rd_en pulsed again before rd_ack fell");
    end

endmodule

bind qdr_cpu_bridge qdr_cpu_bridge_chk chk0 (
  .bus_clk (bus_clk),
  .bus_rst (bus_rst),
  .qdr_clk (qdr_clk),
  .qdr_rst (qdr_rst),
  .bus_rsp (bus_rsp),
  .qdr_cmd (qdr_cmd),
  .rd_ack  (rd_ack)
);

/* test/qdr_cpu_bridge_tb.sv */
`timescale 1ns/1ps
`include "qdr_config.svh"

module qdr_cpu_bridge_tb
  import qdr_bus_pkg::*;
  import qdr_mem_pkg::*;
();

  typedef enum logic [2:0] {
    OP_WR,
    OP_RD,
    OP_PHY,
    OP_POLL,
    OP_BURST,
    OP_NOACK,
    OP_COUNT
  } op_kind_t;

  typedef struct packed {
    op_kind_t    kind;
    reg_word_t   word;
    logic [31:0] data;
  } op_t;

  localparam int ACK_TIMEOUT = 8;
  localparam int POLL_LIMIT  = 40;
  localparam int IDX_W       = $clog2(`QDR_MEM_WORDS);

  logic        bus_clk;
  logic        bus_rst;
  logic        qdr_clk;
  logic        qdr_rst;
  bus_req_t    bus_req;
  bus_rsp_t    bus_rsp;
  phy_status_t phy_status;
  qdr_cmd_t    qdr_cmd;
  qdr_rsp_t    qdr_rsp;

  op_t          ops [$];
  logic [31:0]  lcg_state;
  int           exp_reads;
  logic [31:0]  rd_pulses;
  logic [31:0]  addr_shadow;
  logic [143:0] wr_shadow;
  burst_t       mem_rec [`QDR_MEM_WORDS];

  qdr_cpu_bridge dut0 (
    .bus_clk    (bus_clk),
    .bus_rst    (bus_rst),
    .qdr_clk    (qdr_clk),
    .qdr_rst    (qdr_rst),
    .bus_req    (bus_req),
    .bus_rsp    (bus_rsp),
    .phy_status (phy_status),
    .qdr_cmd    (qdr_cmd),
    .qdr_rsp    (qdr_rsp)
  );

  qdr_mem_model mem0 (
    .qdr_clk (qdr_clk),
    .qdr_cmd (qdr_cmd),
    .qdr_rsp (qdr_rsp)
  );

  initial begin
    qdr_clk = 1'b0;
    forever #4 qdr_clk = ~qdr_clk;
  end

  initial begin
    bus_clk = 1'b0;
    forever #6 bus_clk = ~bus_clk;
  end

  initial begin
    qdr_rst = 1'b1;
    repeat (2) @(negedge qdr_clk);
    qdr_rst = 1'b0;
  end

  // every read burst leaves exactly one rd_en cycle.
  always @(posedge qdr_clk) begin
    if (qdr_rst) begin
      rd_pulses <= '0;
    end else if (qdr_cmd.rd_en) begin
      rd_pulses <= rd_pulses + 32'd1;
    end
  end

  always @(negedge qdr_clk) begin
    if (dut0.chk0.any_fail) begin
      $display("an assertion in the bound checker failed");
      abort_run();
    end
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [31:0] word_addr(input reg_word_t word);
    return `QDR_BASE_ADDR + {25'b0, word, 2'b00};
  endfunction

  function automatic void add_op(input op_kind_t kind, input reg_word_t word,
                                 input logic [31:0] data);
    ops.push_back('{kind: kind, word: word, data: data});
  endfunction

  task automatic abort_run();
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_burst(input burst_t got, input burst_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t rd_burst got %h expected %h", $time, got, exp);
      abort_run();
    end
  endtask

  task automatic check_phy(input phy_status_t got, input phy_status_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t phy_status got rdy=%b fail=%b expected rdy=%b fail=%b",
               $time, got.phy_rdy, got.cal_fail, exp.phy_rdy, exp.cal_fail);
      abort_run();
    end
  endtask

  // select stays up until xfer_ack is seen or the limit runs out.
  task automatic bus_access(input logic rnw, input logic [31:0] addr, input logic [31:0] wdata,
                            input int limit, output logic [31:0] rdata, output logic acked);
    int waited;
    @(negedge bus_clk);
    bus_req = '{addr: addr, wdata: wdata, rnw: rnw, select: 1'b1};
    waited = 0;
    acked = 1'b0;
    rdata = '0;
    while (!acked && waited < limit) begin
      @(negedge bus_clk);
      waited++;
      if (bus_rsp.xfer_ack) begin
        acked = 1'b1;
        rdata = bus_rsp.rdata;
      end
    end
    // a select held past its acknowledge is not taken again in the next cycle.
    if (acked) begin
      @(negedge bus_clk);
      check_word("xfer_ack after a held select", {31'b0, bus_rsp.xfer_ack}, '0);
    end
    bus_req.select = 1'b0;
  endtask

  task automatic bus_rw(input logic rnw, input reg_word_t word, input logic [31:0] wdata,
                        output logic [31:0] rdata);
    logic acked;
    bus_access(rnw, word_addr(word), wdata, ACK_TIMEOUT, rdata, acked);
    if (!acked) begin
      $display("no xfer_ack on a bus access to word %0d", word);
      abort_run();
    end
  endtask

  task automatic poll_idle();
    logic [31:0] ctrl;
    int polls;
    ctrl = 32'h0000_0101;
    polls = 0;
    while (ctrl[0] || ctrl[8]) begin
      if (polls == POLL_LIMIT) begin
        $display("pending bits in the control word never cleared");
        abort_run();
      end
      bus_rw(1'b1, REG_CTRL, '0, ctrl);
      polls++;
    end
  endtask

  // keeps the expected memory contents as the host would see them.
  task automatic note_write(input reg_word_t word, input logic [31:0] data);
    case (word)
      REG_ADDR: addr_shadow = data;
      REG_WR0:  wr_shadow[143:128] = data[15:0];
      REG_WR1, REG_WR2, REG_WR3, REG_WR4: wr_shadow[32 * (12 - int'(word)) +: 32] = data;
      REG_CTRL: begin
        if (data[8] && !data[0]) begin
          mem_rec[addr_shadow[IDX_W-1:0]] = wr_shadow;
        end
      end
      default: ;
    endcase
  endtask

  task automatic add_burst_write(input logic [31:0] addr);
    add_op(OP_WR, REG_ADDR, addr);
    for (int k = 0; k < 5; k++) begin
      add_op(OP_WR, reg_word_t'(5'(8 + k)), next_rand());
    end
    add_op(OP_WR, REG_CTRL, 32'h0000_0100);
    add_op(OP_POLL, REG_CTRL, '0);
  endtask

  task automatic add_burst_read(input logic [31:0] addr, input bit second_go);
    add_op(OP_WR, REG_ADDR, addr);
    add_op(OP_WR, REG_CTRL, 32'h0000_0001);
    if (second_go) begin
      add_op(OP_WR, REG_CTRL, 32'h0000_0001);
    end
    add_op(OP_POLL, REG_CTRL, '0);
    add_op(OP_BURST, REG_RD0, addr);
    exp_reads++;
  endtask

  task automatic build_table();
    logic [31:0] v;
    logic [31:0] a_one;
    logic [31:0] a_two;
    for (int i = 0; i < 4; i++) begin
      add_op(OP_PHY, REG_STATUS, 32'(i));
    end
    v = next_rand();
    add_op(OP_WR, REG_ADDR, v);
    add_op(OP_RD, REG_ADDR, v);
    for (int k = 0; k < 5; k++) begin
      v = next_rand();
      add_op(OP_WR, reg_word_t'(5'(8 + k)), v);
      add_op(OP_RD, reg_word_t'(5'(8 + k)), (k == 0) ? {16'b0, v[15:0]} : v);
    end
    // the two addresses differ in the low bits that index the memory.
    a_one = next_rand();
    a_two = a_one ^ 32'h0000_0015;
    add_burst_write(a_one);
    add_burst_read(a_one, 1'b0);
    add_burst_write(a_one);
    add_burst_write(a_two);
    add_burst_read(a_one, 1'b0);
    add_burst_read(a_two, 1'b0);
    add_op(OP_NOACK, REG_STATUS, `QDR_HIGH_ADDR);
    add_op(OP_NOACK, REG_STATUS, `QDR_BASE_ADDR - 32'd4);
    add_op(OP_RD, reg_word_t'(5'd5), '0);
    add_burst_read(a_two, 1'b1);
    add_op(OP_COUNT, REG_STATUS, 32'(exp_reads));
  endtask

  task automatic apply_op(input op_t op);
    logic [31:0] rd;
    logic [31:0] words [5];
    logic acked;
    phy_status_t exp_phy;
    phy_status_t got_phy;
    int polls;
    case (op.kind)
      OP_WR: begin
        bus_rw(1'b0, op.word, op.data, rd);
        note_write(op.word, op.data);
      end
      OP_RD: begin
        bus_rw(1'b1, op.word, '0, rd);
        check_word($sformatf("rdata of word %0d", op.word), rd, op.data);
      end
      OP_PHY: begin
        exp_phy = phy_status_t'(op.data[1:0]);
        @(negedge bus_clk);
        phy_status = exp_phy;
        got_phy = '{phy_rdy: ~exp_phy.phy_rdy, cal_fail: ~exp_phy.cal_fail};
        polls = 0;
        while (got_phy != exp_phy && polls < POLL_LIMIT) begin
          bus_rw(1'b1, REG_STATUS, '0, rd);
          got_phy = '{phy_rdy: rd[0], cal_fail: rd[8]};
          polls++;
        end
        check_phy(got_phy, exp_phy);
      end
      OP_POLL: poll_idle();
      OP_BURST: begin
        for (int k = 0; k < 5; k++) begin
          bus_rw(1'b1, reg_word_t'(5'(16 + k)), '0, words[k]);
        end
        check_burst(burst_t'({words[0][15:0], words[1], words[2], words[3], words[4]}),
                    mem_rec[op.data[IDX_W-1:0]]);
      end
      OP_NOACK: begin
        bus_access(1'b1, op.data, '0, 4, rd, acked);
        check_word("xfer_ack", {31'b0, acked}, '0);
      end
      OP_COUNT: check_word("rd_en pulses", rd_pulses, op.data);
      default: ;
    endcase
  endtask

  initial begin
    bus_rst = 1'b1;
    bus_req = '0;
    phy_status = '0;
    lcg_state = 32'd74;
    exp_reads = 0;
    addr_shadow = '0;
    wr_shadow = '0;
    build_table();
    repeat (2) @(negedge bus_clk);
    bus_rst = 1'b0;
    foreach (ops[i]) begin
      apply_op(ops[i]);
    end
    if (dut0.chk0.any_fail) begin
      $display("an assertion in the bound checker failed");
      abort_run();
    end else begin
      $display("Everything OK");
      $finish;
    end
  end

endmodule

/* test/qdr_mem_model.sv */
`timescale 1ns/1ps
`include "qdr_config.svh"

module qdr_mem_model
  import qdr_mem_pkg::*;
(
  input  logic     qdr_clk,
  input  qdr_cmd_t qdr_cmd,
  output qdr_rsp_t qdr_rsp
);

  localparam int IDX_W = $clog2(`QDR_MEM_WORDS);

  burst_t           mem [`QDR_MEM_WORDS];
  logic [IDX_W-1:0] wr_idx;
  logic             wr_lo;
  logic [IDX_W-1:0] rd_idx;
  logic [2:0]       rd_pipe;

  initial begin
    for (int i = 0; i < `QDR_MEM_WORDS; i++) begin
      mem[i] = {9{16'(i)}};
    end
    wr_lo   = 1'b0;
    wr_idx  = '0;
    rd_idx  = '0;
    rd_pipe = '0;
    qdr_rsp = '0;
  end

  // the lo beat of a write is on wr_data one cycle after wr_en.
  always @(posedge qdr_clk) begin
    wr_lo <= (qdr_cmd.wr_en === 1'b1);
    if (qdr_cmd.wr_en === 1'b1) begin
      wr_idx <= qdr_cmd.address[IDX_W-1:0];
      mem[qdr_cmd.address[IDX_W-1:0]].hi <= qdr_cmd.wr_data;
    end
    if (wr_lo) begin
      mem[wr_idx].lo <= qdr_cmd.wr_data;
    end
  end

  // hi beat three cycles after rd_en, lo beat right behind it.
  always @(posedge qdr_clk) begin
    rd_pipe <= {rd_pipe[1:0], qdr_cmd.rd_en === 1'b1};
    if (qdr_cmd.rd_en === 1'b1) begin
      rd_idx <= qdr_cmd.address[IDX_W-1:0];
    end
    qdr_rsp.rd_dvld <= rd_pipe[1] | rd_pipe[2];
    qdr_rsp.rd_data <= rd_pipe[1] ? mem[rd_idx].hi : (rd_pipe[2] ? mem[rd_idx].lo : '0);
  end

endmodule
